/* design/membus_pkg.sv */
package membus_pkg;

  localparam int BEAT_W     = 64;
  localparam int LINE_BEATS = 8;
  // a 64 byte line spans 16 bus words
  localparam int LINE_WORDS = 16;

  // bus word address, byte address bits 31 down to 2
  typedef logic [31:2] word_addr_t;

  typedef logic [4:0] bus_tag_t;

  typedef logic [BEAT_W-1:0] beat_t;

  typedef logic [LINE_BEATS*BEAT_W-1:0] line_t;

  // cycle index inside the eight cycle slot
  typedef logic [2:0] slot_phase_t;

  typedef enum logic [2:0] {
    idle      = 3'd0,
    bus_rd    = 3'd1,
    bus_rdx   = 3'd2,
    flush     = 3'd3,
    flush_opt = 3'd4,
    fill      = 3'd5
  } bus_cmd_e;

  // addr is relative to the start of the DRAM window
  typedef struct packed {
    logic       write;
    bus_tag_t   tag;
    word_addr_t addr;
    line_t      line;
  } dram_req_t;

  typedef struct packed {
    bus_tag_t   tag;
    word_addr_t addr;
    line_t      line;
  } dram_resp_t;

endpackage

/* design/bus_snoop_capture.sv */
`timescale 1ns/100ps

module bus_snoop_capture
  import membus_pkg::*;
#(
  parameter word_addr_t  RAM_BASE  = 30'h0800_0000,
  parameter int unsigned RAM_WORDS = 8192
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_valid,
  input  logic        bus_nack,
  input  logic        bus_hit,
  input  bus_cmd_e    bus_cmd,
  input  bus_tag_t    bus_tag,
  input  word_addr_t  bus_addr,
  input  beat_t       bus_data,
  input  logic        full,
  output slot_phase_t slot_phase,
  output dram_req_t   req_in,
  output logic        req_strobe,
  output logic        dram_nack
);

  slot_phase_t phase;
  word_addr_t  rel_addr;
  logic        is_mem_cmd;
  logic        is_write;
  logic        relevant;
  logic        cmd_valid;
  logic        cmd_write;
  bus_tag_t    cmd_tag;
  word_addr_t  cmd_addr;
  line_t       line_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= '0;
    end else begin
      phase <= phase + 3'd1;
    end
  end

  assign slot_phase = phase;

  always_comb begin
    is_mem_cmd = 1'b1;
    is_write   = 1'b0;
    case (bus_cmd)
      bus_rd, bus_rdx:  is_write = 1'b0;
      flush, flush_opt: is_write = 1'b1;
      default:          is_mem_cmd = 1'b0;
    endcase
  end

  assign rel_addr = bus_addr - RAM_BASE;
  assign relevant = bus_valid & ~bus_nack & ~bus_hit & is_mem_cmd &
                    (bus_addr >= RAM_BASE) & (rel_addr < RAM_WORDS);

  // accept or nack in phase 3, hand over at phase 0 once beat 7 is in
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid  <= 1'b0;
      dram_nack  <= 1'b0;
      req_strobe <= 1'b0;
    end else begin
      req_strobe <= (phase == 3'd7) & cmd_valid;
      if (phase == 3'd3) begin
        cmd_valid <= relevant & ~full;
        dram_nack <= relevant & full;
      end else if (phase == 3'd7) begin
        cmd_valid <= 1'b0;
        dram_nack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (phase == 3'd3) begin
      cmd_write <= is_write;
      cmd_tag   <= bus_tag;
      cmd_addr  <= rel_addr;
    end
  end

  // beat k of the slot lands in beat k of the line
  always_ff @(posedge clk) begin
    line_r[phase*BEAT_W +: BEAT_W] <= bus_data;
  end

  assign req_in = '{write: cmd_write, tag: cmd_tag, addr: cmd_addr, line: line_r};

  a_strobe_phase: assert property (@(posedge clk) disable iff (rst)
    req_strobe |-> phase == 3'd0);

endmodule

/* design/dram_request_queue.sv */
`timescale 1ns/100ps

module dram_request_queue
  import membus_pkg::*;
#(
  parameter int QUEUE_DEPTH  = 4,
  parameter int LINES        = 512,
  parameter int DRAM_LATENCY = 12
) (
  input  logic        clk,
  input  logic        rst,
  input  dram_req_t   req_in,
  input  logic        req_strobe,
  input  slot_phase_t slot_phase,
  input  logic        resp_taken,
  output logic        full,
  output dram_resp_t  resp,
  output logic        resp_valid
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int IDX_W = (LINES > 1) ? $clog2(LINES) : 1;
  localparam int LAT_W = $clog2(DRAM_LATENCY + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_hold
  } eng_state_e;

  dram_req_t        fifo_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pending;
  logic             pop;

  line_t            line_mem [LINES];
  eng_state_e       state;
  dram_req_t        cur_req;
  logic [LAT_W-1:0] lat_cnt;
  logic [IDX_W-1:0] line_idx;
  logic             mem_access;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // a command accepted in phase 3 is only written at the next phase 0
  assign pending = (slot_phase > 3'd3) | req_strobe;
  assign full    = (32'(count) + 32'(pending)) >= QUEUE_DEPTH;

  assign pop = (state == st_idle) && (count != '0);

  always_ff @(posedge clk) begin
    if (req_strobe) begin
      fifo_mem[wr_ptr] <= req_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_strobe) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(req_strobe) - CNT_W'(pop);
    end
  end

  // engine: idle -> access for DRAM_LATENCY cycles -> hold until the fill is granted
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      lat_cnt    <= '0;
      resp_valid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (pop) begin
            state   <= st_access;
            lat_cnt <= LAT_W'(DRAM_LATENCY - 1);
          end
        end
        st_access: begin
          if (lat_cnt == '0) begin
            if (cur_req.write) begin
              state <= st_idle;
            end else begin
              state      <= st_hold;
              resp_valid <= 1'b1;
            end
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        st_hold: begin
          if (resp_taken) begin
            state      <= st_idle;
            resp_valid <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      cur_req <= fifo_mem[rd_ptr];
    end
  end

  assign line_idx   = IDX_W'((cur_req.addr / LINE_WORDS) % LINES);
  assign mem_access = (state == st_access) && (lat_cnt == '0);

  always_ff @(posedge clk) begin
    if (mem_access && cur_req.write) begin
      line_mem[line_idx] <= cur_req.line;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_access && !cur_req.write) begin
      resp <= '{tag: cur_req.tag, addr: cur_req.addr, line: line_mem[line_idx]};
    end
  end

  // capture must have nacked anything that would overflow
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    req_strobe |-> count < QUEUE_DEPTH);

  a_taken_valid: assert property (@(posedge clk) disable iff (rst)
    resp_taken |-> resp_valid);

endmodule

/* design/fill_responder.sv */
`timescale 1ns/100ps

module fill_responder
  import membus_pkg::*;
#(
  parameter word_addr_t RAM_BASE = 30'h0800_0000
) (
  input  logic        clk,
  input  logic        rst,
  input  slot_phase_t slot_phase,
  input  dram_resp_t  resp,
  input  logic        resp_valid,
  input  logic        bus_grant,
  output logic        resp_taken,
  output logic        dram_req,
  output bus_cmd_e    dram_cmd,
  output bus_tag_t    dram_tag,
  output word_addr_t  dram_addr,
  output beat_t       dram_data,
  output logic        dram_fill
);

  typedef enum logic [1:0] {
    st_wait,
    st_request,
    st_fill
  } fill_state_e;

  fill_state_e state;
  dram_resp_t  fill_r;
  logic        slot_end;
  logic        granted;

  assign slot_end = (slot_phase == 3'd7);
  assign granted  = slot_end & (state == st_request) & bus_grant;

  // all bus side changes happen on the phase 7 edge
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_wait;
      dram_req   <= 1'b0;
      dram_fill  <= 1'b0;
      resp_taken <= 1'b0;
    end else begin
      resp_taken <= granted;
      if (slot_end) begin
        dram_fill <= granted;
        case (state)
          st_wait: begin
            if (resp_valid) begin
              state    <= st_request;
              dram_req <= 1'b1;
            end
          end
          st_request: begin
            if (bus_grant) begin
              state    <= st_fill;
              dram_req <= 1'b0;
            end
          end
          st_fill: begin
            // next response may already be waiting
            state    <= resp_valid ? st_request : st_wait;
            dram_req <= resp_valid;
          end
          default: state <= st_wait;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (granted) begin
      fill_r <= resp;
    end
  end

  assign dram_cmd  = dram_fill ? fill : idle;
  assign dram_tag  = fill_r.tag;
  assign dram_addr = fill_r.addr + RAM_BASE;
  assign dram_data = fill_r.line[slot_phase*BEAT_W +: BEAT_W];

  a_fill_start: assert property (@(posedge clk) disable iff (rst)
    $rose(dram_fill) |-> slot_phase == 3'd0);

endmodule

/* design/dram_ctrl_top.sv */
`timescale 1ns/100ps

module dram_ctrl_top
  import membus_pkg::*;
#(
  parameter word_addr_t  RAM_BASE     = word_addr_t'(32'h2000_0000 >> 2),
  parameter int unsigned RAM_WORDS    = 8192,
  parameter int          QUEUE_DEPTH  = 4,
  parameter int          LINES        = 512,
  parameter int          DRAM_LATENCY = 12
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       bus_valid,
  input  logic       bus_nack,
  input  logic       bus_hit,
  input  bus_cmd_e   bus_cmd,
  input  bus_tag_t   bus_tag,
  input  word_addr_t bus_addr,
  input  beat_t      bus_data,
  input  logic       bus_grant,
  output logic       dram_req,
  output bus_cmd_e   dram_cmd,
  output bus_tag_t   dram_tag,
  output word_addr_t dram_addr,
  output beat_t      dram_data,
  output logic       dram_fill,
  output logic       dram_nack
);

  slot_phase_t slot_phase;
  dram_req_t   req_in;
  logic        req_strobe;
  logic        full;
  dram_resp_t  resp;
  logic        resp_valid;
  logic        resp_taken;

  bus_snoop_capture #(
    .RAM_BASE  (RAM_BASE),
    .RAM_WORDS (RAM_WORDS)
  ) u_capture (
    .clk        (clk),
    .rst        (rst),
    .bus_valid  (bus_valid),
    .bus_nack   (bus_nack),
    .bus_hit    (bus_hit),
    .bus_cmd    (bus_cmd),
    .bus_tag    (bus_tag),
    .bus_addr   (bus_addr),
    .bus_data   (bus_data),
    .full       (full),
    .slot_phase (slot_phase),
    .req_in     (req_in),
    .req_strobe (req_strobe),
    .dram_nack  (dram_nack)
  );

  dram_request_queue #(
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .LINES        (LINES),
    .DRAM_LATENCY (DRAM_LATENCY)
  ) u_queue (
    .clk        (clk),
    .rst        (rst),
    .req_in     (req_in),
    .req_strobe (req_strobe),
    .slot_phase (slot_phase),
    .resp_taken (resp_taken),
    .full       (full),
    .resp       (resp),
    .resp_valid (resp_valid)
  );

  fill_responder #(
    .RAM_BASE (RAM_BASE)
  ) u_responder (
    .clk        (clk),
    .rst        (rst),
    .slot_phase (slot_phase),
    .resp       (resp),
    .resp_valid (resp_valid),
    .bus_grant  (bus_grant),
    .resp_taken (resp_taken),
    .dram_req   (dram_req),
    .dram_cmd   (dram_cmd),
    .dram_tag   (dram_tag),
    .dram_addr  (dram_addr),
    .dram_data  (dram_data),
    .dram_fill  (dram_fill)
  );

endmodule

/* verification/dram_ctrl_tb.sv */
`timescale 1ns/100ps

module dram_ctrl_tb
  import membus_pkg::*;
();

  localparam word_addr_t RAM_BASE     = 30'h0800_0000;
  localparam int         RAM_WORDS    = 8192;
  localparam int         QUEUE_DEPTH  = 4;
  localparam int         DRAM_LATENCY = 12;
  localparam int         FILL_WAIT    = 320;
  // all tests together need well under 100 slots
  localparam int         MAX_CYCLES   = 6000;

  logic        clk;
  logic        rst;
  logic        bus_valid;
  logic        bus_nack;
  logic        bus_hit;
  logic        bus_grant;
  bus_cmd_e    bus_cmd;
  bus_tag_t    bus_tag;
  word_addr_t  bus_addr;
  beat_t       bus_data;
  logic        dram_req;
  logic        dram_fill;
  logic        dram_nack;
  bus_cmd_e    dram_cmd;
  bus_tag_t    dram_tag;
  word_addr_t  dram_addr;
  beat_t       dram_data;

  slot_phase_t phase;
  integer      seed = 27;
  int          data_errors;
  int          ctrl_errors;
  line_t       ref_mem [word_addr_t];

  dram_ctrl_top #(
    .RAM_BASE     (RAM_BASE),
    .RAM_WORDS    (RAM_WORDS),
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .DRAM_LATENCY (DRAM_LATENCY)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .bus_valid (bus_valid),
    .bus_nack  (bus_nack),
    .bus_hit   (bus_hit),
    .bus_cmd   (bus_cmd),
    .bus_tag   (bus_tag),
    .bus_addr  (bus_addr),
    .bus_data  (bus_data),
    .bus_grant (bus_grant),
    .dram_req  (dram_req),
    .dram_cmd  (dram_cmd),
    .dram_tag  (dram_tag),
    .dram_addr (dram_addr),
    .dram_data (dram_data),
    .dram_fill (dram_fill),
    .dram_nack (dram_nack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // read right after an edge this is the phase of the cycle just ended
  always @(posedge clk) begin
    if (rst) begin
      phase <= '0;
    end else begin
      phase <= phase + 3'd1;
    end
  end

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < 16; i++) begin
      l[i*32 +: 32] = $random(seed);
    end
    return l;
  endfunction

  function automatic word_addr_t line_addr(input int n);
    return RAM_BASE + word_addr_t'(n * LINE_WORDS);
  endfunction

  task automatic align_to_slot();
    while (phase != 3'd7) begin
      @(posedge clk);
    end
  endtask

  // one full slot with the command in phase 3 and beat k in phase k
  task automatic issue_cmd(input bus_cmd_e cmd, input bus_tag_t tag, input word_addr_t addr,
                           input line_t line, input logic hit, input logic nack,
                           output logic nacked);
    nacked = 1'b0;
    align_to_slot();
    for (int k = 0; k < 8; k++) begin
      bus_data  <= line[k*BEAT_W +: BEAT_W];
      bus_valid <= (k == 3);
      bus_cmd   <= (k == 3) ? cmd : idle;
      bus_tag   <= tag;
      bus_addr  <= addr;
      bus_hit   <= (k == 3) & hit;
      bus_nack  <= (k == 3) & nack;
      @(posedge clk);
      if (k >= 4 && dram_nack) begin
        nacked = 1'b1;
      end
    end
  endtask

  task automatic send_cmd(input bus_cmd_e cmd, input bus_tag_t tag, input word_addr_t addr,
                          input line_t line, input logic hit, input logic nack,
                          input logic exp_nack);
    logic nacked;
    issue_cmd(cmd, tag, addr, line, hit, nack, nacked);
    assert (nacked == exp_nack) else begin
      ctrl_errors++;
      $display("Error at %0t: tag %0d nack %b, expected %b", $time, tag, nacked, exp_nack);
    end
  endtask

  task automatic wait_fill(input bus_tag_t tag, input word_addr_t addr);
    int    waited;
    line_t got;
    waited = 0;
    while (!(phase == 3'd6 && dram_req) && waited < FILL_WAIT) begin
      @(posedge clk);
      waited++;
    end
    assert (waited < FILL_WAIT) else begin
      ctrl_errors++;
      $display("No fill request showed up for tag %0d within %0d cycles", tag, FILL_WAIT);
    end
    if (waited < FILL_WAIT) begin
      // grant is sampled at the end of phase 7
      bus_grant <= 1'b1;
      @(posedge clk);
      bus_grant <= 1'b0;
      for (int k = 0; k < 8; k++) begin
        @(posedge clk);
        assert (dram_fill && dram_cmd == fill && dram_tag == tag && dram_addr == addr)
        else begin
          ctrl_errors++;
          $display("Error at %0t: beat %0d fill %b cmd %0d tag %0d addr %h, want tag %0d addr %h",
                   $time, k, dram_fill, dram_cmd, dram_tag, dram_addr, tag, addr);
        end
        got[k*BEAT_W +: BEAT_W] = dram_data;
      end
      assert (got === ref_mem[addr]) else begin
        data_errors++;
        $display("Error at %0t: fill data for tag %0d at %h does not match", $time, tag, addr);
      end
    end
  endtask

  task automatic check_bus_level(input int slots, input logic exp_req);
    repeat (slots * 8) begin
      @(posedge clk);
      assert (dram_req == exp_req && !dram_fill) else begin
        ctrl_errors++;
        $display("Error at %0t: dram_req %b dram_fill %b, expected req %b and no fill",
                 $time, dram_req, dram_fill, exp_req);
      end
    end
  endtask

  task automatic test_write_read();
    word_addr_t a;
    line_t      d;
    a = line_addr(5);
    d = rand_line();
    ref_mem[a] = d;
    send_cmd(flush, 5'd1, a, d, 1'b0, 1'b0, 1'b0);
    send_cmd(bus_rd, 5'd2, a, rand_line(), 1'b0, 1'b0, 1'b0);
    wait_fill(5'd2, a);
  endtask

  task automatic test_filter();
    word_addr_t a;
    line_t      d;
    a = line_addr(9);
    d = rand_line();
    ref_mem[a] = d;
    send_cmd(flush_opt, 5'd3, a, d, 1'b0, 1'b0, 1'b0);
    send_cmd(flush, 5'd4, a, rand_line(), 1'b1, 1'b0, 1'b0);
    send_cmd(flush, 5'd5, a, rand_line(), 1'b0, 1'b1, 1'b0);
    // one window size above and below would alias the same array line
    send_cmd(flush, 5'd6, a + word_addr_t'(RAM_WORDS), rand_line(), 1'b0, 1'b0, 1'b0);
    send_cmd(flush, 5'd7, a - word_addr_t'(RAM_WORDS), rand_line(), 1'b0, 1'b0, 1'b0);
    send_cmd(idle, 5'd8, a, rand_line(), 1'b0, 1'b0, 1'b0);
    send_cmd(bus_rdx, 5'd9, a, '0, 1'b0, 1'b0, 1'b0);
    wait_fill(5'd9, a);
  endtask

  task automatic test_order();
    line_t d;
    for (int i = 0; i < 3; i++) begin
      d = rand_line();
      ref_mem[line_addr(20 + 7*i)] = d;
      send_cmd(flush, bus_tag_t'(10 + i), line_addr(20 + 7*i), d, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 3; i++) begin
      send_cmd(bus_rd, bus_tag_t'(16 + i), line_addr(20 + 7*i), '0, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 3; i++) begin
      wait_fill(bus_tag_t'(16 + i), line_addr(20 + 7*i));
    end
  endtask

  task automatic test_full_backpressure();
    int lines [7] = '{5, 9, 20, 27, 34, 9, 20};
    // fifo entries plus the one held by the engine
    for (int i = 0; i < 7; i++) begin
      send_cmd(bus_rd, bus_tag_t'(24 + i), line_addr(lines[i]), '0, 1'b0, 1'b0,
               i > QUEUE_DEPTH);
    end
    // with the queue full any command that gets past the filter is nacked
    send_cmd(flush, 5'd31, line_addr(5), '0, 1'b1, 1'b0, 1'b0);
    send_cmd(bus_rd, 5'd31, line_addr(5), '0, 1'b0, 1'b1, 1'b0);
    send_cmd(bus_rd, 5'd31, line_addr(5) + word_addr_t'(RAM_WORDS), '0, 1'b0, 1'b0, 1'b0);
    send_cmd(idle, 5'd31, line_addr(5), '0, 1'b0, 1'b0, 1'b0);
    check_bus_level(4, 1'b1);
    for (int i = 0; i <= QUEUE_DEPTH; i++) begin
      wait_fill(bus_tag_t'(24 + i), line_addr(lines[i]));
    end
    check_bus_level(4, 1'b0);
  endtask

  initial begin
    rst         = 1'b1;
    bus_valid   = 1'b0;
    bus_nack    = 1'b0;
    bus_hit     = 1'b0;
    bus_grant   = 1'b0;
    bus_cmd     = idle;
    bus_tag     = '0;
    bus_addr    = '0;
    bus_data    = '0;
    data_errors = 0;
    ctrl_errors = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_write_read();
    test_filter();
    test_order();
    test_full_backpressure();
    $display("Run complete, data errors: %0d, control errors: %0d", data_errors, ctrl_errors);
    if (data_errors + ctrl_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

/* files.f */
design/membus_pkg.sv
design/bus_snoop_capture.sv
design/dram_request_queue.sv
design/fill_responder.sv
design/dram_ctrl_top.sv
verification/dram_ctrl_tb.sv

/* Bender.yml */
package:
  name: dram_ctrl

dependencies: {}

sources:
  - files:
      - design/membus_pkg.sv
      - design/bus_snoop_capture.sv
      - design/dram_request_queue.sv
      - design/fill_responder.sv
      - design/dram_ctrl_top.sv
  - target: test
    files:
      - verification/dram_ctrl_tb.sv
